//--- compile.f
+incdir+.
klClkPkg.sv
diagConfigRegs.sv
burstCounter.sv
gateControl.sv
parityErrors.sv
diagReadMux.sv
klClkBoard.sv
klClkBoardTb.sv

//--- Makefile
TOP = klClkBoardTb

.PHONY: all lint clean

all:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- klClkBoardTb.sv
//////////////////////////////////////////////////////////////////////
// Table-driven self-checking testbench for the clock control board
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "klClk_macros.svh"

module klClkBoardTb;

  import klClkPkg::*;

  typedef enum logic [3:0] {
    opLoad, opFunc, opParity, opRead, opPulses, opSpan, opQuiet, opSection, opStop, opPins
  } opCode_t;

  typedef struct packed {
    opCode_t     op;
    logic [2:0]  sel;
    logic [5:0]  data;
    logic [15:0] expVal;
  } step_t;

  logic       CLK;
  logic       rstN;
  logic       diagCtlFunc;
  logic       diagLdFunc;
  logic       diagRead;
  diagSel_t   diagSel;
  ebusData_t  ebusIn;
  parityIn_t  parity;
  logic       eboxClkEn;
  logic       errorStop;
  logic       mrReset;
  logic       ebusDrive;
  sectionEn_t sectionEn;
  ebusData_t  ebusOut;

  step_t steps[$];
  string names[$];
  int    errCount;
  int    pulseCount;
  int    crmCount;
  int    edpCount;
  int    ctlCount;

  // Expected configuration from the load field layouts
  logic [1:0] srcSel;
  logic [1:0] rate;
  logic [2:0] dis;
  logic [3:0] parChk;
  logic       mbox;
  logic       stopEn;

  klClkBoard uut (
    .CLK(CLK), .rstN(rstN), .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc),
    .diagRead(diagRead), .diagSel(diagSel), .ebusIn(ebusIn), .parity(parity),
    .eboxClkEn(eboxClkEn), .errorStop(errorStop), .mrReset(mrReset),
    .ebusDrive(ebusDrive), .sectionEn(sectionEn), .ebusOut(ebusOut)
  );

  always #10 CLK = ~CLK;

  task automatic checkValue(input string name, input int expVal, input int actVal);
    if (expVal != actVal) begin
      $display("mismatch %s: expected 'h%0h actual 'h%0h", name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic addStep(input string name, input opCode_t op, input logic [2:0] sel,
                         input int data, input int expVal);
    step_t st;
    st.op = op;
    st.sel = sel;
    st.data = 6'(data);
    st.expVal = 16'(expVal);
    steps.push_back(st);
    names.push_back(name);
  endtask

  // Stop any run, load both nibbles, start the burst and count pulses
  task automatic addBurst(input string name, input int n);
    addStep({name, " stop"}, opFunc, 3'd0, 0, 0);
    addStep({name, " msb"}, opLoad, `KL_LD_BURST_MSB, n >> 4, 0);
    addStep({name, " lsb"}, opLoad, `KL_LD_BURST_LSB, n % 16, 0);
    addStep({name, " go"}, opFunc, `KL_FN_BURST, 0, 0);
    addStep({name, " pulses"}, opPulses, 3'd0, 0, n);
    addStep({name, " read 0"}, opRead, `KL_RD_BURST_MSB, 0, 0);
    addStep({name, " read 1"}, opRead, `KL_RD_BURST_LSB, 0, 0);
  endtask

  task automatic loadRandom(input logic [2:0] sel);
    int    d;
    string tag;
    d = int'($urandom % 64);
    case (sel)
      `KL_LD_RATE: begin
        srcSel = d[3:2];
        rate = d[1:0];
      end
      `KL_LD_DISABLE: dis = d[2:0];
      `KL_LD_PARITY:  parChk = d[3:0];
      default: begin
        mbox = d[3];
        stopEn = d[0];
      end
    endcase
    tag = $sformatf("load%0d data %0h", sel, d);
    addStep(tag, opLoad, sel, d, 0);
    addStep({tag, " read 4"}, opRead, `KL_RD_RATE, 0, int'({srcSel, rate, mbox, 1'b0}));
    addStep({tag, " read 5"}, opRead, `KL_RD_DISABLE, 0, int'({dis, stopEn, 2'b00}));
    addStep({tag, " read 6"}, opRead, `KL_RD_PARITY, 0, int'({parChk, 2'b00}));
  endtask

  task automatic buildTable();
    int i;
    for (i = 0; i < 8; i++) begin
      addStep($sformatf("reset read %0d", i), opRead, 3'(i), 0, 0);
    end
    addStep("reset pins", opPins, 3'd0, 0, 0);
    for (i = 0; i < 8; i++) begin
      loadRandom(3'(4 + i % 4));
    end
    addStep("clear rate", opLoad, `KL_LD_RATE, 0, 0);
    addStep("clear disable", opLoad, `KL_LD_DISABLE, 0, 0);
    addStep("clear parity", opLoad, `KL_LD_PARITY, 0, 0);
    addStep("clear misc", opLoad, `KL_LD_MISC, 0, 0);
    addBurst("burst1", 1);
    addBurst("burst16", 16);
    addBurst("burst20", 20);
    addStep("rate 2", opLoad, `KL_LD_RATE, 2, 0);
    addBurst("burst7 rate2", 7);
    addStep("rate 0", opLoad, `KL_LD_RATE, 0, 0);
    addStep("step go", opFunc, `KL_FN_SINGLE_STEP, 0, 0);
    addStep("step pulses", opPulses, 3'd0, 0, 1);
    addStep("rate 3", opLoad, `KL_LD_RATE, 3, 0);
    addStep("start go", opFunc, `KL_FN_START, 0, 0);
    addStep("start 10 pulses min 70 cycles", opSpan, 3'd0, 10, 70);
    addStep("start stop", opFunc, 3'd0, 0, 0);
    addStep("start stopped", opQuiet, 3'd0, 0, 0);
    addStep("rate 0 again", opLoad, `KL_LD_RATE, 0, 0);
    // Only the EDP section stays enabled
    addStep("disable crm ctl", opLoad, `KL_LD_DISABLE, 5, 0);
    addBurst("burst4 sections", 4);
    addStep("section crm", opSection, 3'd2, 0, 0);
    addStep("section edp", opSection, 3'd1, 0, 4);
    addStep("section ctl", opSection, 3'd0, 0, 0);
    addStep("enable sections", opLoad, `KL_LD_DISABLE, 0, 0);
    addStep("dram check", opLoad, `KL_LD_PARITY, 2, 0);
    addStep("dram bad", opParity, 3'd0, 'b0110, 0);
    addStep("dram step", opFunc, `KL_FN_SINGLE_STEP, 0, 0);
    addStep("dram pulses", opPulses, 3'd0, 0, 1);
    addStep("dram error read", opRead, `KL_RD_ERRORS, 0, 'b100000);
    addStep("fs check", opLoad, `KL_LD_PARITY, 1, 0);
    addStep("fs stop enable", opLoad, `KL_LD_MISC, 1, 0);
    addStep("fs fault", opParity, 3'd0, 'b1111, 0);
    addStep("fs start", opFunc, `KL_FN_START, 0, 0);
    addStep("fs error stop", opStop, 3'd0, 0, 0);
    addStep("fs pulses ceased", opQuiet, 3'd0, 0, 0);
    addStep("fs run read", opRead, `KL_RD_RUN, 0, 'b110000);
    addStep("fs error read", opRead, `KL_RD_ERRORS, 0, 'b100100);
    addStep("fs pins", opPins, 3'd0, 0, 'b10);
    addStep("fs fault off", opParity, 3'd0, 'b1110, 0);
    addStep("clear reset", opFunc, `KL_FN_CLR_RESET, 0, 0);
    addStep("clear reset pins", opPins, 3'd0, 0, 'b01);
    addStep("clear reset run read", opRead, `KL_RD_RUN, 0, 'b000010);
    addStep("clear reset error read", opRead, `KL_RD_ERRORS, 0, 0);
    addStep("set reset", opFunc, `KL_FN_SET_RESET, 0, 0);
    addStep("set reset pins", opPins, 3'd0, 0, 0);
    addStep("set reset run read", opRead, `KL_RD_RUN, 0, 0);
  endtask

  task automatic clearCounts();
    pulseCount = 0;
    crmCount = 0;
    edpCount = 0;
    ctlCount = 0;
  endtask

  task automatic samplePulse();
    @(negedge CLK);
    if (eboxClkEn) pulseCount++;
    if (sectionEn.crm) crmCount++;
    if (sectionEn.edp) edpCount++;
    if (sectionEn.ctl) ctlCount++;
  endtask

  task automatic runStep(input step_t st, input string name);
    int cyc;
    int limit;
    int secVal;
    cyc = 0;
    case (st.op)
      opLoad, opFunc: begin
        @(negedge CLK);
        diagSel = st.sel;
        ebusIn = st.data;
        diagLdFunc = (st.op == opLoad);
        diagCtlFunc = (st.op == opFunc);
        @(negedge CLK);
        diagLdFunc = 1'b0;
        diagCtlFunc = 1'b0;
      end
      opParity: begin
        @(negedge CLK);
        parity = parityIn_t'(st.data[3:0]);
      end
      opRead: begin
        @(negedge CLK);
        diagSel = st.sel;
        diagRead = 1'b1;
        #5;
        checkValue({name, " drive"}, 1, int'(ebusDrive));
        checkValue(name, int'(st.expVal), int'(ebusOut));
        @(negedge CLK);
        diagRead = 1'b0;
        #5;
        checkValue({name, " idle"}, 0, int'({ebusDrive, ebusOut}));
      end
      opPulses: begin
        clearCounts();
        limit = 8 * int'(st.expVal) + 16;
        while (pulseCount < int'(st.expVal) && cyc < limit) begin
          samplePulse();
          cyc++;
        end
        if (pulseCount < int'(st.expVal)) begin
          $display("timeout in %s after %0d cycles, only %0d pulses", name, cyc, pulseCount);
          errCount++;
        end
        // Extra pulses after the expected count are errors too
        repeat (16) samplePulse();
        checkValue(name, int'(st.expVal), pulseCount);
      end
      opSpan: begin
        clearCounts();
        limit = 8 * int'(st.data) + 32;
        while (pulseCount < int'(st.data) && cyc < limit) begin
          samplePulse();
          cyc++;
        end
        if (pulseCount < int'(st.data)) begin
          $display("timeout in %s after %0d cycles, only %0d pulses", name, cyc, pulseCount);
          errCount++;
        end
        checkValue(name, 1, (cyc >= int'(st.expVal)) ? 1 : 0);
      end
      opQuiet: begin
        clearCounts();
        repeat (16) samplePulse();
        checkValue(name, int'(st.expVal), pulseCount);
      end
      opSection: begin
        case (st.sel)
          3'd2:    secVal = crmCount;
          3'd1:    secVal = edpCount;
          default: secVal = ctlCount;
        endcase
        checkValue(name, int'(st.expVal), secVal);
      end
      opStop: begin
        while (!errorStop && cyc < 64) begin
          @(negedge CLK);
          cyc++;
        end
        if (!errorStop) begin
          $display("errorStop did not rise within %0d cycles in %s", cyc, name);
          errCount++;
        end
      end
      default: begin
        @(negedge CLK);
        checkValue(name, int'(st.expVal), int'({errorStop, mrReset}));
      end
    endcase
  endtask

  initial begin
    int i;
    int errBefore;
    int testCount;
    int failCount;
    CLK = 1'b0;
    rstN = 1'b0;
    diagCtlFunc = 1'b0;
    diagLdFunc = 1'b0;
    diagRead = 1'b0;
    diagSel = '0;
    ebusIn = '0;
    parity = parityIn_t'(4'b1110);
    errCount = 0;
    testCount = 0;
    failCount = 0;
    srcSel = '0;
    rate = '0;
    dis = '0;
    parChk = '0;
    mbox = 1'b0;
    stopEn = 1'b0;
    clearCounts();
    void'($urandom(32'h4159));
    buildTable();
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    rstN = 1'b1;
    for (i = 0; i < steps.size(); i++) begin
      errBefore = errCount;
      runStep(steps[i], names[i]);
      if (steps[i].op >= opRead) begin
        testCount++;
        if (errCount != errBefore) failCount++;
        $display("%-40s %s", names[i], (errCount == errBefore) ? "pass" : "fail");
      end
    end
    $display("%0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- klClkBoard.sv
//////////////////////////////////////////////////////////////////////
// Diagnostic clock control board top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module klClkBoard (
  input  logic                 CLK,
  input  logic                 rstN,
  input  logic                 diagCtlFunc,
  input  logic                 diagLdFunc,
  input  logic                 diagRead,
  input  klClkPkg::diagSel_t   diagSel,
  input  klClkPkg::ebusData_t  ebusIn,
  input  klClkPkg::parityIn_t  parity,
  output logic                 eboxClkEn,
  output logic                 errorStop,
  output logic                 mrReset,
  output logic                 ebusDrive,
  output klClkPkg::sectionEn_t sectionEn,
  output klClkPkg::ebusData_t  ebusOut
);

  import klClkPkg::*;

  funcStrobes_t funcs;
  clkConfig_t   cfg;
  logic         ldBurstLsb;
  logic         ldBurstMsb;
  burstCount_t  count;
  logic         burstZero;
  runState_t    run;
  logic         errClear;
  errorStatus_t errs;

  diagConfigRegs cfgRegs (
    .CLK(CLK), .rstN(rstN), .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc),
    .diagSel(diagSel), .ebusIn(ebusIn), .funcs(funcs),
    .ldBurstLsb(ldBurstLsb), .ldBurstMsb(ldBurstMsb), .cfg(cfg)
  );

  burstCounter burstCnt (
    .CLK(CLK), .rstN(rstN), .ldLsb(ldBurstLsb), .ldMsb(ldBurstMsb), .data(ebusIn),
    .burstMode(run.burst), .eboxClkEn(eboxClkEn), .count(count), .burstZero(burstZero)
  );

  gateControl gate (
    .CLK(CLK), .rstN(rstN), .funcs(funcs), .rateSel(cfg.rateSel),
    .burstZero(burstZero), .errorStop(errs.errorStop),
    .eboxClkEn(eboxClkEn), .run(run), .errClear(errClear)
  );

  parityErrors parErr (
    .CLK(CLK), .rstN(rstN), .eboxClkEn(eboxClkEn), .errClear(errClear),
    .parity(parity), .cfg(cfg), .errs(errs)
  );

  diagReadMux readMux (
    .diagRead(diagRead), .diagSel(diagSel), .count(count), .run(run),
    .errs(errs), .cfg(cfg), .ebusDrive(ebusDrive), .ebusOut(ebusOut)
  );

  // Per-section EBOX clock enables
  assign sectionEn.crm = eboxClkEn & ~cfg.crmDis;
  assign sectionEn.edp = eboxClkEn & ~cfg.edpDis;
  assign sectionEn.ctl = eboxClkEn & ~cfg.ctlDis;

  assign errorStop = errs.errorStop;
  assign mrReset   = run.mrReset;

endmodule

//--- diagReadMux.sv
//////////////////////////////////////////////////////////////////////
// Diagnostic bus readback selected by the diagnostic select code
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "klClk_macros.svh"

module diagReadMux (
  input  logic                   diagRead,
  input  klClkPkg::diagSel_t     diagSel,
  input  klClkPkg::burstCount_t  count,
  input  klClkPkg::runState_t    run,
  input  klClkPkg::errorStatus_t errs,
  input  klClkPkg::clkConfig_t   cfg,
  output logic                   ebusDrive,
  output klClkPkg::ebusData_t    ebusOut
);

  assign ebusDrive = diagRead;

  // Fields listed from bit 5 down
  always_comb begin
    ebusOut = '0;
    if (diagRead) begin
      case (diagSel)
        `KL_RD_BURST_MSB: ebusOut = {2'b00, count[7:4]};
        `KL_RD_BURST_LSB: ebusOut = {2'b00, count[3:0]};
        `KL_RD_RUN:       ebusOut = {errs.errorStop, run.go, run.burst,
                                     run.stepPending, run.mrReset, 1'b0};
        `KL_RD_ERRORS:    ebusOut = {errs.dramParErr, errs.cramParErr,
                                     errs.fmParErr, errs.fsErr, 2'b00};
        `KL_RD_RATE:      ebusOut = {cfg.sourceSel, cfg.rateSel,
                                     cfg.mboxCycleDis, 1'b0};
        `KL_RD_DISABLE:   ebusOut = {cfg.crmDis, cfg.edpDis, cfg.ctlDis,
                                     cfg.errStopEn, 2'b00};
        `KL_RD_PARITY:    ebusOut = {cfg.fmParCheck, cfg.cramParCheck,
                                     cfg.dramParCheck, cfg.fsCheck, 2'b00};
        `KL_RD_SPARE:     ebusOut = '0;
        default:          ebusOut = '0;
      endcase
    end
  end

endmodule

//--- parityErrors.sv
//////////////////////////////////////////////////////////////////////
// Parity and field-service error capture with error stop latch
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module parityErrors (
  input  logic                   CLK,
  input  logic                   rstN,
  input  logic                   eboxClkEn,
  input  logic                   errClear,
  input  klClkPkg::parityIn_t    parity,
  input  klClkPkg::clkConfig_t   cfg,
  output klClkPkg::errorStatus_t errs
);

  logic fsHit;

  assign fsHit = cfg.fsCheck && parity.fsFault;

  // Errors are sticky until clear reset
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      errs <= '0;
    end else if (errClear) begin
      errs <= '0;
    end else if (eboxClkEn) begin
      if (cfg.dramParCheck && !parity.dramOddParity) errs.dramParErr <= 1'b1;
      if (cfg.cramParCheck && !parity.cramPar)       errs.cramParErr <= 1'b1;
      if (cfg.fmParCheck && !parity.fmOddParity)     errs.fmParErr   <= 1'b1;
      if (fsHit)                                     errs.fsErr      <= 1'b1;
      // Field service fault stops the clock when enabled
      if (fsHit && cfg.errStopEn)                    errs.errorStop  <= 1'b1;
    end
  end

endmodule

//--- gateControl.sv
//////////////////////////////////////////////////////////////////////
// Rate prescaler, run latches, master reset and EBOX pulse gating
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module gateControl (
  input  logic                   CLK,
  input  logic                   rstN,
  input  klClkPkg::funcStrobes_t funcs,
  input  klClkPkg::rateSel_t     rateSel,
  input  logic                   burstZero,
  input  logic                   errorStop,
  output logic                   eboxClkEn,
  output klClkPkg::runState_t    run,
  output logic                   errClear
);

  logic [2:0] prescale;
  logic [2:0] rateMask;
  logic       rateTick;
  logic       pulseNext;

  // Divide by 1, 2, 4 or 8
  always_comb begin
    case (rateSel)
      2'd0:    rateMask = 3'b000;
      2'd1:    rateMask = 3'b001;
      2'd2:    rateMask = 3'b011;
      default: rateMask = 3'b111;
    endcase
  end

  assign rateTick = (prescale & rateMask) == 3'b000;

  assign pulseNext = rateTick && !errorStop &&
                     (run.go || (run.burst && !burstZero) || run.stepPending);

  assign errClear = funcs.clrReset;

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 3'd1;
    end
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      eboxClkEn <= 1'b0;
    end else begin
      eboxClkEn <= pulseNext;
    end
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      run <= '0;
    end else begin
      // Any control function reloads all three run latches
      if (funcs.anyFunc) begin
        run.go          <= funcs.start;
        run.burst       <= funcs.burst;
        run.stepPending <= funcs.singleStep;
      end else if (pulseNext) begin
        run.stepPending <= 1'b0;
      end
      // Master reset flip-flop
      if (funcs.clrReset) begin
        run.mrReset <= 1'b1;
      end else if (funcs.setReset) begin
        run.mrReset <= 1'b0;
      end
    end
  end

endmodule

//--- burstCounter.sv
//////////////////////////////////////////////////////////////////////
// Burst mode pulse counter, loaded one nibble at a time
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module burstCounter (
  input  logic                  CLK,
  input  logic                  rstN,
  input  logic                  ldLsb,
  input  logic                  ldMsb,
  input  klClkPkg::ebusData_t   data,
  input  logic                  burstMode,
  input  logic                  eboxClkEn,
  output klClkPkg::burstCount_t count,
  output logic                  burstZero
);

  logic decrement;

  assign decrement = eboxClkEn && burstMode && (count != '0);

  // Looks ahead past a decrement in flight, so the gate sees the
  // last pulse of a burst in time even at the full rate
  assign burstZero = (count == '0) || (decrement && (count == 8'd1));

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (ldLsb) begin
      count[3:0] <= data[3:0];
    end else if (ldMsb) begin
      count[7:4] <= data[3:0];
    end else if (decrement) begin
      count <= count - 8'd1;
    end
  end

endmodule

//--- diagConfigRegs.sv
//////////////////////////////////////////////////////////////////////
// Diagnostic function decode and clock configuration registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "klClk_macros.svh"

module diagConfigRegs (
  input  logic                   CLK,
  input  logic                   rstN,
  input  logic                   diagCtlFunc,
  input  logic                   diagLdFunc,
  input  klClkPkg::diagSel_t     diagSel,
  input  klClkPkg::ebusData_t    ebusIn,
  output klClkPkg::funcStrobes_t funcs,
  output logic                   ldBurstLsb,
  output logic                   ldBurstMsb,
  output klClkPkg::clkConfig_t   cfg
);

  logic ldRate;
  logic ldDisable;
  logic ldParity;
  logic ldMisc;

  // Control function decode
  // Codes 0, 3 and 4 only reload the run latches
  always_comb begin
    funcs = '0;
    funcs.anyFunc = diagCtlFunc;
    if (diagCtlFunc) begin
      case (diagSel)
        `KL_FN_START:       funcs.start = 1'b1;
        `KL_FN_SINGLE_STEP: funcs.singleStep = 1'b1;
        `KL_FN_BURST:       funcs.burst = 1'b1;
        `KL_FN_CLR_RESET:   funcs.clrReset = 1'b1;
        `KL_FN_SET_RESET:   funcs.setReset = 1'b1;
        default:            ;
      endcase
    end
  end

  // Load strobes
  assign ldBurstLsb = diagLdFunc && (diagSel == `KL_LD_BURST_LSB);
  assign ldBurstMsb = diagLdFunc && (diagSel == `KL_LD_BURST_MSB);
  assign ldRate     = diagLdFunc && (diagSel == `KL_LD_RATE);
  assign ldDisable  = diagLdFunc && (diagSel == `KL_LD_DISABLE);
  assign ldParity   = diagLdFunc && (diagSel == `KL_LD_PARITY);
  assign ldMisc     = diagLdFunc && (diagSel == `KL_LD_MISC);

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      cfg <= '0;
    end else begin
      if (ldRate) begin
        cfg.sourceSel <= ebusIn[3:2];
        cfg.rateSel   <= ebusIn[1:0];
      end
      if (ldDisable) begin
        cfg.crmDis <= ebusIn[2];
        cfg.edpDis <= ebusIn[1];
        cfg.ctlDis <= ebusIn[0];
      end
      if (ldParity) begin
        cfg.fmParCheck   <= ebusIn[3];
        cfg.cramParCheck <= ebusIn[2];
        cfg.dramParCheck <= ebusIn[1];
        cfg.fsCheck      <= ebusIn[0];
      end
      // Only cycle disable and error stop enable survive in 047
      if (ldMisc) begin
        cfg.mboxCycleDis <= ebusIn[3];
        cfg.errStopEn    <= ebusIn[0];
      end
    end
  end

endmodule

//--- klClkPkg.sv
//////////////////////////////////////////////////////////////////////
// Clock board types: data words, strobes, configuration, errors
//////////////////////////////////////////////////////////////////////
`include "klClk_macros.svh"

package klClkPkg;

  typedef logic [`KL_EBUS_W-1:0]     ebusData_t;
  typedef logic [`KL_DIAG_SEL_W-1:0] diagSel_t;
  typedef logic [`KL_BURST_W-1:0]    burstCount_t;
  typedef logic [`KL_RATE_W-1:0]     rateSel_t;

  // One-cycle decoded control functions
  typedef struct packed {
    logic start;
    logic singleStep;
    logic burst;
    logic clrReset;
    logic setReset;
    logic anyFunc;
  } funcStrobes_t;

  typedef struct packed {
    logic [1:0] sourceSel;
    rateSel_t   rateSel;
    logic       crmDis;
    logic       edpDis;
    logic       ctlDis;
    logic       fmParCheck;
    logic       cramParCheck;
    logic       dramParCheck;
    logic       fsCheck;
    logic       mboxCycleDis;
    logic       errStopEn;
  } clkConfig_t;

  typedef struct packed {
    logic dramOddParity;
    logic cramPar;
    logic fmOddParity;
    logic fsFault;
  } parityIn_t;

  typedef struct packed {
    logic dramParErr;
    logic cramParErr;
    logic fmParErr;
    logic fsErr;
    logic errorStop;
  } errorStatus_t;

  typedef struct packed {
    logic go;
    logic burst;
    logic stepPending;
    logic mrReset;
  } runState_t;

  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } sectionEn_t;

endpackage

//--- klClk_macros.svh
//////////////////////////////////////////////////////////////////////
// Clock board widths, diagnostic function, load and read select codes
//////////////////////////////////////////////////////////////////////
`ifndef KL_CLK_MACROS_SVH
`define KL_CLK_MACROS_SVH

`define KL_EBUS_W      6
`define KL_DIAG_SEL_W  3
`define KL_BURST_W     8
`define KL_RATE_W      2

// Control functions (00x)
`define KL_FN_START        3'd1
`define KL_FN_SINGLE_STEP  3'd2
`define KL_FN_BURST        3'd5
`define KL_FN_CLR_RESET    3'd6
`define KL_FN_SET_RESET    3'd7

// Load functions (04x)
`define KL_LD_BURST_LSB  3'd2
`define KL_LD_BURST_MSB  3'd3
`define KL_LD_RATE       3'd4
`define KL_LD_DISABLE    3'd5
`define KL_LD_PARITY     3'd6
`define KL_LD_MISC       3'd7

// Read selects
`define KL_RD_BURST_MSB  3'd0
`define KL_RD_BURST_LSB  3'd1
`define KL_RD_RUN        3'd2
`define KL_RD_ERRORS     3'd3
`define KL_RD_RATE       3'd4
`define KL_RD_DISABLE    3'd5
`define KL_RD_PARITY     3'd6
`define KL_RD_SPARE      3'd7

`endif
